// File: common/mem_pkg.sv
package mem_pkg;

   // Access kind from the core's load/store unit
   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,
      MEM_LB   = 4'd1,
      MEM_LH   = 4'd2,
      MEM_LW   = 4'd3,
      MEM_LBU  = 4'd4,
      MEM_LHU  = 4'd5,
      MEM_SB   = 4'd6,
      MEM_SH   = 4'd7,
      MEM_SW   = 4'd8
   } mem_op_e;

   // One bus word, seen as byte lanes or halfword lanes
   typedef union packed {
      logic [3:0][7:0]  b;
      logic [1:0][15:0] h;
   } mem_word_u;

   // UART register map, byte offsets from the UART base
   localparam logic [31:0] UART_DATA_OFS = 32'h0;
   localparam logic [31:0] UART_STAT_OFS = 32'h4;

   // Status word layout
   localparam int UART_BUSY_BIT = 0;

endpackage

// File: verilog/lsu_ctrl.sv
`timescale 1ns/10ps

module lsu_ctrl (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              req_i,
   input  mem_pkg::mem_op_e  op_i,
   input  logic [31:0]       addr_i,
   input  logic [31:0]       wdata_i,
   input  logic [31:0]       bus_rdata_i,
   output logic              bus_rd_o,
   output logic              bus_wr_o,
   output logic [29:0]       bus_addr_o,
   output logic [3:0]        bus_mask_o,
   output logic [31:0]       bus_wdata_o,
   output logic [31:0]       rdata_o,
   output logic              rvalid_o,
   output logic              exception_o
);

   logic                is_load;
   logic                is_store;
   logic                is_byte;
   logic                is_half;
   logic                misalign;
   mem_pkg::mem_word_u  st_word;
   mem_pkg::mem_word_u  ld_word;
   logic [7:0]          ld_byte;
   logic [15:0]         ld_half;
   mem_pkg::mem_op_e    ld_op_q;
   logic [1:0]          ld_ofs_q;
   logic                rvalid_q;

   always_comb begin
      is_load  = 1'b0;
      is_store = 1'b0;
      is_byte  = 1'b0;
      is_half  = 1'b0;
      case (op_i)
         mem_pkg::MEM_LB, mem_pkg::MEM_LBU: begin
            is_load = 1'b1;
            is_byte = 1'b1;
         end
         mem_pkg::MEM_LH, mem_pkg::MEM_LHU: begin
            is_load = 1'b1;
            is_half = 1'b1;
         end
         mem_pkg::MEM_LW: is_load = 1'b1;
         mem_pkg::MEM_SB: begin
            is_store = 1'b1;
            is_byte  = 1'b1;
         end
         mem_pkg::MEM_SH: begin
            is_store = 1'b1;
            is_half  = 1'b1;
         end
         mem_pkg::MEM_SW: is_store = 1'b1;
         default: ;
      endcase
   end

   // Halfwords need bit 0 clear, words need both low bits clear
   assign misalign = is_half ? addr_i[0] : (!is_byte && (addr_i[1:0] != 2'b00));

   assign exception_o = req_i && (is_load || is_store) && misalign;
   assign bus_rd_o    = req_i && is_load && !misalign;
   assign bus_wr_o    = req_i && is_store && !misalign;
   assign bus_addr_o  = addr_i[31:2];

   always_comb begin
      if (is_byte)
         bus_mask_o = 4'b0001 << addr_i[1:0];
      else if (is_half)
         bus_mask_o = addr_i[1] ? 4'b1100 : 4'b0011;
      else
         bus_mask_o = 4'b1111;
   end

   // Replicate store data so the masked lanes carry it
   always_comb begin
      st_word = wdata_i;
      if (is_byte)
         st_word.b = {4{wdata_i[7:0]}};
      else if (is_half)
         st_word.h = {2{wdata_i[15:0]}};
   end

   assign bus_wdata_o = st_word;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ld_op_q  <= mem_pkg::MEM_NONE;
         ld_ofs_q <= 2'b00;
         rvalid_q <= 1'b0;
      end else begin
         ld_op_q  <= op_i;
         ld_ofs_q <= addr_i[1:0];
         rvalid_q <= bus_rd_o;
      end
   end

   assign rvalid_o = rvalid_q;

   // Lane select and extension on the returned word
   always_comb begin
      ld_word = bus_rdata_i;
      ld_byte = ld_word.b[ld_ofs_q];
      ld_half = ld_word.h[ld_ofs_q[1]];
      case (ld_op_q)
         mem_pkg::MEM_LB:  rdata_o = {{24{ld_byte[7]}}, ld_byte};
         mem_pkg::MEM_LBU: rdata_o = {24'h0, ld_byte};
         mem_pkg::MEM_LH:  rdata_o = {{16{ld_half[15]}}, ld_half};
         mem_pkg::MEM_LHU: rdata_o = {16'h0, ld_half};
         default:          rdata_o = ld_word;
      endcase
   end

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder #(
   parameter int          RAM_AW    = 8,
   parameter logic [31:0] RAM_BASE  = 32'h0,
   parameter logic [31:0] UART_BASE = 32'h100
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              bus_rd_i,
   input  logic              bus_wr_i,
   input  logic [29:0]       bus_addr_i,
   input  logic [3:0]        bus_mask_i,
   input  logic [31:0]       bus_wdata_i,
   input  logic [31:0]       ram_rdata_i,
   input  logic [31:0]       uart_rdata_i,
   output logic [31:0]       bus_rdata_o,
   output logic              ram_we_o,
   output logic [RAM_AW-1:0] ram_addr_o,
   output logic [3:0]        ram_mask_o,
   output logic [31:0]       ram_wdata_o,
   output logic              uart_wr_o,
   output logic              uart_sel_stat_o,
   output logic [7:0]        uart_wdata_o
);

   // Word addresses of both targets
   localparam logic [29:0] RAM_WBASE  = RAM_BASE[31:2];
   localparam logic [29:0] RAM_WSIZE  = 30'(2 ** RAM_AW);
   localparam logic [31:0] UART_DATA  = UART_BASE + mem_pkg::UART_DATA_OFS;
   localparam logic [31:0] UART_STAT  = UART_BASE + mem_pkg::UART_STAT_OFS;

   logic        ram_hit;
   logic        uart_data_hit;
   logic        uart_stat_hit;
   logic [29:0] ram_ofs;
   logic        rd_ram_q;
   logic        rd_uart_q;

   assign ram_ofs       = bus_addr_i - RAM_WBASE;
   assign ram_hit       = (bus_addr_i >= RAM_WBASE) && (ram_ofs < RAM_WSIZE);
   assign uart_data_hit = (bus_addr_i == UART_DATA[31:2]);
   assign uart_stat_hit = (bus_addr_i == UART_STAT[31:2]);

   assign ram_we_o    = bus_wr_i && ram_hit;
   assign ram_addr_o  = ram_ofs[RAM_AW-1:0];
   assign ram_mask_o  = bus_mask_i;
   assign ram_wdata_o = bus_wdata_i;

   // Only a write that covers the low byte reaches the transmitter
   assign uart_wr_o       = bus_wr_i && uart_data_hit && bus_mask_i[0];
   assign uart_sel_stat_o = bus_rd_i && uart_stat_hit;
   assign uart_wdata_o    = bus_wdata_i[7:0];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ram_q  <= 1'b0;
         rd_uart_q <= 1'b0;
      end else begin
         rd_ram_q  <= bus_rd_i && ram_hit;
         rd_uart_q <= bus_rd_i && (uart_data_hit || uart_stat_hit);
      end
   end

   // Unmapped reads return zero
   assign bus_rdata_o = rd_ram_q  ? ram_rdata_i :
                        rd_uart_q ? uart_rdata_i : 32'h0;

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/10ps

module data_ram #(
   parameter int RAM_AW = 8
) (
   input  logic              clk,
   input  logic              we_i,
   input  logic [RAM_AW-1:0] addr_i,
   input  logic [3:0]        mask_i,
   input  logic [31:0]       wdata_i,
   output logic [31:0]       rdata_o
);

   localparam int DEPTH = 2 ** RAM_AW;

   logic [3:0][7:0] mem [DEPTH];
   logic [3:0][7:0] wdata;
   logic [31:0]     rdata_q;

   assign wdata = wdata_i;

   // Byte-masked write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         for (int i = 0; i < 4; i++) begin
            if (mask_i[i])
               mem[addr_i][i] <= wdata[i];
         end
      end
   end

   // Read every cycle, old data on a same-cycle write
   always_ff @(posedge clk) begin
      rdata_q <= mem[addr_i];
   end

   assign rdata_o = rdata_q;

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 4
) (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        wr_i,
   input  logic        sel_stat_i,
   input  logic [7:0]  wdata_i,
   output logic [31:0] rdata_o,
   output logic        txd_o
);

   localparam int          CNT_W    = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [3:0]  LAST_BIT = 4'd9;

   logic             busy_q;
   logic [CNT_W-1:0] baud_cnt_q;
   logic [3:0]       bit_idx_q;
   logic [9:0]       shift_q;
   logic [31:0]      status;
   logic [31:0]      rdata_q;
   logic             start;
   logic             bit_done;

   // Writes while busy are dropped
   assign start    = wr_i && !busy_q;
   assign bit_done = busy_q && (baud_cnt_q == CNT_LAST);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q     <= 1'b0;
         baud_cnt_q <= '0;
         bit_idx_q  <= 4'd0;
      end else if (start) begin
         busy_q     <= 1'b1;
         baud_cnt_q <= '0;
         bit_idx_q  <= 4'd0;
      end else if (bit_done) begin
         baud_cnt_q <= '0;
         if (bit_idx_q == LAST_BIT)
            busy_q <= 1'b0;
         else
            bit_idx_q <= bit_idx_q + 4'd1;
      end else if (busy_q) begin
         baud_cnt_q <= baud_cnt_q + 1'b1;
      end
   end

   // Frame is stop, data LSB first, start; shifted out from bit 0
   always_ff @(posedge clk) begin
      if (start)
         shift_q <= {1'b1, wdata_i, 1'b0};
      else if (bit_done)
         shift_q <= {1'b1, shift_q[9:1]};
   end

   assign txd_o = busy_q ? shift_q[0] : 1'b1;

   always_comb begin
      status = 32'h0;
      status[mem_pkg::UART_BUSY_BIT] = busy_q;
   end

   // Status read data, one cycle after the select
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         rdata_q <= 32'h0;
      else
         rdata_q <= sel_stat_i ? status : 32'h0;
   end

   assign rdata_o = rdata_q;

endmodule

// File: verilog/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top #(
   parameter int          RAM_AW       = 8,
   parameter logic [31:0] RAM_BASE     = 32'h0,
   parameter logic [31:0] UART_BASE    = 32'h100,
   parameter int          CLKS_PER_BIT = 4
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              req_i,
   input  mem_pkg::mem_op_e  op_i,
   input  logic [31:0]       addr_i,
   input  logic [31:0]       wdata_i,
   output logic [31:0]       rdata_o,
   output logic              rvalid_o,
   output logic              exception_o,
   output logic              uart_txd_o
);

   logic              bus_rd;
   logic              bus_wr;
   logic [29:0]       bus_addr;
   logic [3:0]        bus_mask;
   logic [31:0]       bus_wdata;
   logic [31:0]       bus_rdata;

   logic              ram_we;
   logic [RAM_AW-1:0] ram_addr;
   logic [3:0]        ram_mask;
   logic [31:0]       ram_wdata;
   logic [31:0]       ram_rdata;

   logic              uart_wr;
   logic              uart_sel_stat;
   logic [7:0]        uart_wdata;
   logic [31:0]       uart_rdata;

   // Core side
   lsu_ctrl lsu_ctrl_i (
      .clk,
      .arst_n_i,
      .req_i,
      .op_i,
      .addr_i,
      .wdata_i,
      .bus_rdata_i (bus_rdata),
      .bus_rd_o    (bus_rd),
      .bus_wr_o    (bus_wr),
      .bus_addr_o  (bus_addr),
      .bus_mask_o  (bus_mask),
      .bus_wdata_o (bus_wdata),
      .rdata_o,
      .rvalid_o,
      .exception_o
   );

   bus_decoder #(
      .RAM_AW    (RAM_AW),
      .RAM_BASE  (RAM_BASE),
      .UART_BASE (UART_BASE)
   ) bus_decoder_i (
      .clk,
      .arst_n_i,
      .bus_rd_i        (bus_rd),
      .bus_wr_i        (bus_wr),
      .bus_addr_i      (bus_addr),
      .bus_mask_i      (bus_mask),
      .bus_wdata_i     (bus_wdata),
      .ram_rdata_i     (ram_rdata),
      .uart_rdata_i    (uart_rdata),
      .bus_rdata_o     (bus_rdata),
      .ram_we_o        (ram_we),
      .ram_addr_o      (ram_addr),
      .ram_mask_o      (ram_mask),
      .ram_wdata_o     (ram_wdata),
      .uart_wr_o       (uart_wr),
      .uart_sel_stat_o (uart_sel_stat),
      .uart_wdata_o    (uart_wdata)
   );

   data_ram #(.RAM_AW(RAM_AW)) data_ram_i (
      .clk,
      .we_i    (ram_we),
      .addr_i  (ram_addr),
      .mask_i  (ram_mask),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata)
   );

   // Serial port
   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
      .clk,
      .arst_n_i,
      .wr_i       (uart_wr),
      .sel_stat_i (uart_sel_stat),
      .wdata_i    (uart_wdata),
      .rdata_o    (uart_rdata),
      .txd_o      (uart_txd_o)
   );

endmodule

// File: dv/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb;

   localparam int CLKS_PER_BIT = 4;
   localparam int CLK_PERIOD   = 100;

   logic             clk;
   logic             arst_n_i;
   logic             req_i;
   mem_pkg::mem_op_e op_i;
   logic [31:0]      addr_i;
   logic [31:0]      wdata_i;
   logic [31:0]      rdata_o;
   logic             rvalid_o;
   logic             exception_o;
   logic             uart_txd_o;

   string            names[$];
   mem_pkg::mem_op_e ops[$];
   logic [31:0]      addrs[$];
   logic [31:0]      wdatas[$];
   logic [31:0]      exp_rdata[$];
   logic [31:0]      exp_exc[$];
   logic [31:0]      exp_tx[$];

   int               pass_cnt;
   int               fail_cnt;
   int               n_cases;
   logic             cases_loaded;
   logic             rx_active;
   logic [7:0]       rx_exp;

   // UART sits just above the 1 KiB RAM window
   mem_subsys_top #(.UART_BASE(32'h400)) mem_subsys_top_i (
      .clk,
      .arst_n_i,
      .req_i,
      .op_i,
      .addr_i,
      .wdata_i,
      .rdata_o,
      .rvalid_o,
      .exception_o,
      .uart_txd_o
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         fail_cnt++;
      end else begin
         pass_cnt++;
      end
   endtask

   function automatic mem_pkg::mem_op_e op_from_name(input string s, output logic ok);
      ok = 1'b1;
      case (s)
         "NONE": return mem_pkg::MEM_NONE;
         "LB":   return mem_pkg::MEM_LB;
         "LH":   return mem_pkg::MEM_LH;
         "LW":   return mem_pkg::MEM_LW;
         "LBU":  return mem_pkg::MEM_LBU;
         "LHU":  return mem_pkg::MEM_LHU;
         "SB":   return mem_pkg::MEM_SB;
         "SH":   return mem_pkg::MEM_SH;
         "SW":   return mem_pkg::MEM_SW;
         default: begin
            ok = 1'b0;
            return mem_pkg::MEM_NONE;
         end
      endcase
   endfunction

   task automatic load_cases();
      int               fd;
      int               n;
      string            line;
      string            name;
      string            op_name;
      logic [31:0]      addr_v;
      logic [31:0]      wdata_v;
      logic [31:0]      rdata_v;
      logic [31:0]      exc_v;
      logic [31:0]      tx_v;
      logic             ok;
      mem_pkg::mem_op_e op;
      fd = $fopen("dv/mem_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the case file dv/mem_cases.txt");
         fail_cnt++;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() == 0 || line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%s %s %h %h %h %h %h", name, op_name, addr_v, wdata_v,
                     rdata_v, exc_v, tx_v);
         // Blank line
         if (n <= 0)
            continue;
         if (n != 7) begin
            $display("malformed line in the case file: %s", line);
            fail_cnt++;
            continue;
         end
         op = op_from_name(op_name, ok);
         if (!ok) begin
            $display("unknown operation %s in case %s", op_name, name);
            fail_cnt++;
            continue;
         end
         names.push_back(name);
         ops.push_back(op);
         addrs.push_back(addr_v);
         wdatas.push_back(wdata_v);
         exp_rdata.push_back(rdata_v);
         exp_exc.push_back(exc_v);
         exp_tx.push_back(tx_v);
      end
      $fclose(fd);
   endtask

   // Serial monitor sampling each bit near its middle
   task automatic receive_byte();
      logic [7:0] got;
      int         wait_cnt;
      got      = 8'h0;
      wait_cnt = 0;
      while (uart_txd_o !== 1'b0 && wait_cnt < 4) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (uart_txd_o !== 1'b0) begin
         $display("no start bit on uart_txd_o after the store to the data register");
         fail_cnt++;
      end else begin
         repeat (CLKS_PER_BIT / 2) @(negedge clk);
         check_val("uart_txd_o start bit", 32'(uart_txd_o), 32'h0);
         for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            got[i] = uart_txd_o;
         end
         repeat (CLKS_PER_BIT) @(negedge clk);
         check_val("uart_txd_o stop bit", 32'(uart_txd_o), 32'h1);
         check_val("uart_txd_o byte", 32'(got), 32'(rx_exp));
         $display("uart frame %h received", got);
      end
      rx_active = 1'b0;
   endtask

   task automatic run_case(input int idx);
      int   fails_before;
      logic is_load;
      logic exp_valid;
      fails_before = fail_cnt;
      is_load = ops[idx] inside {mem_pkg::MEM_LB, mem_pkg::MEM_LH, mem_pkg::MEM_LW,
                                 mem_pkg::MEM_LBU, mem_pkg::MEM_LHU};
      exp_valid = is_load && (exp_exc[idx] == 32'h0);
      // Idle step lets a frame finish and busy drop
      if (ops[idx] == mem_pkg::MEM_NONE || exp_tx[idx] != 32'hFF) begin
         wait (rx_active == 1'b0);
         if (ops[idx] == mem_pkg::MEM_NONE)
            repeat (CLKS_PER_BIT) @(posedge clk);
      end
      @(posedge clk);
      req_i   <= 1'b1;
      op_i    <= ops[idx];
      addr_i  <= addrs[idx];
      wdata_i <= wdatas[idx];
      if (exp_tx[idx] != 32'hFF) begin
         rx_exp    = exp_tx[idx][7:0];
         rx_active = 1'b1;
         fork
            receive_byte();
         join_none
      end
      @(negedge clk);
      check_val("exception_o", 32'(exception_o), exp_exc[idx]);
      @(posedge clk);
      req_i <= 1'b0;
      op_i  <= mem_pkg::MEM_NONE;
      @(negedge clk);
      check_val("rvalid_o", 32'(rvalid_o), 32'(exp_valid));
      if (exp_valid)
         check_val("rdata_o", rdata_o, exp_rdata[idx]);
      $display("case %s: %s", names[idx], (fail_cnt == fails_before) ? "ok" : "failed");
   endtask

   initial begin
      wait (cases_loaded);
      #((n_cases * (12 * CLKS_PER_BIT + 4) + 20) * CLK_PERIOD);
      $display("watchdog timeout, the run did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      pass_cnt     = 0;
      fail_cnt     = 0;
      n_cases      = 0;
      cases_loaded = 1'b0;
      rx_active    = 1'b0;
      rx_exp       = 8'h0;
      arst_n_i <= 1'b0;
      req_i    <= 1'b0;
      op_i     <= mem_pkg::MEM_NONE;
      addr_i   <= 32'h0;
      wdata_i  <= 32'h0;
      load_cases();
      n_cases      = names.size();
      cases_loaded = 1'b1;
      repeat (4) @(posedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      check_val("uart_txd_o", 32'(uart_txd_o), 32'h1);
      check_val("rvalid_o", 32'(rvalid_o), 32'h0);
      check_val("exception_o", 32'(exception_o), 32'h0);
      for (int i = 0; i < n_cases; i++)
         run_case(i);
      wait (rx_active == 1'b0);
      $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && n_cases > 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: dv/mem_cases.txt
# name op addr store_data exp_load exp_exception exp_uart_byte (FF means no frame)
# Numbers in hex, RAM at 000-3FF, UART data at 400 and status at 404
sw_w0      SW   000 11223344 00000000 0 FF
lw_w0      LW   000 00000000 11223344 0 FF
sw_w1      SW   004 A5B6C7D8 00000000 0 FF
lw_w1      LW   004 00000000 A5B6C7D8 0 FF
lw_w0_again LW  000 00000000 11223344 0 FF
sw_top     SW   3FC CAFEF00D 00000000 0 FF
lw_top     LW   3FC 00000000 CAFEF00D 0 FF
sw_w2      SW   008 00000000 00000000 0 FF
sb_w2_1    SB   009 000000AB 00000000 0 FF
sh_w2_2    SH   00A 0000BEEF 00000000 0 FF
lw_w2      LW   008 00000000 BEEFAB00 0 FF
sb_w2_0    SB   008 FFFFFF7E 00000000 0 FF
lw_w2_merge LW  008 00000000 BEEFAB7E 0 FF
lb_0       LB   008 00000000 0000007E 0 FF
lb_1       LB   009 00000000 FFFFFFAB 0 FF
lb_2       LB   00A 00000000 FFFFFFEF 0 FF
lb_3       LB   00B 00000000 FFFFFFBE 0 FF
lbu_0      LBU  008 00000000 0000007E 0 FF
lbu_1      LBU  009 00000000 000000AB 0 FF
lbu_2      LBU  00A 00000000 000000EF 0 FF
lbu_3      LBU  00B 00000000 000000BE 0 FF
lh_0       LH   008 00000000 FFFFAB7E 0 FF
lh_2       LH   00A 00000000 FFFFBEEF 0 FF
lh_pos     LH   002 00000000 00001122 0 FF
lhu_0      LHU  008 00000000 0000AB7E 0 FF
lhu_2      LHU  00A 00000000 0000BEEF 0 FF
lh_mis     LH   005 00000000 00000000 1 FF
lw_mis     LW   006 00000000 00000000 1 FF
sh_mis     SH   007 00001234 00000000 1 FF
sw_mis     SW   005 12345678 00000000 1 FF
lw_w1_kept LW   004 00000000 A5B6C7D8 0 FF
tx_byte    SB   400 000000A5 00000000 0 A5
stat_busy  LW   404 00000000 00000001 0 FF
tx_wait    NONE 000 00000000 00000000 0 FF
stat_idle  LW   404 00000000 00000000 0 FF
lw_unmap   LW   800 00000000 00000000 0 FF
lw_gap     LW   408 00000000 00000000 0 FF
sw_unmap   SW   800 DEADBEEF 00000000 0 FF
lw_w0_kept LW   000 00000000 11223344 0 FF

// File: build.f
common/mem_pkg.sv
verilog/lsu_ctrl.sv
verilog/bus_decoder.sv
verilog/data_ram.sv
uart/uart_tx.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=mem_subsys_sim

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --timescale 1ns/10ps --top-module mem_subsys_tb \
   -f build.f -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1
